//--- hw/axil_pkg.sv
/*
 * AXI4-Lite widths and encodings for a 32-bit data bus with an 8-bit address.
 * Only the OKAY and SLVERR responses are used by this design.
 */
package axil_pkg;

  // Byte addresses on the bus
  localparam int unsigned AXIL_ADDR_W = 8;
  localparam int unsigned AXIL_DATA_W = 32;
  // One strobe bit per data byte
  localparam int unsigned AXIL_STRB_W = AXIL_DATA_W / 8;
  localparam int unsigned AXIL_PROT_W = 3;
  localparam int unsigned AXIL_RESP_W = 2;

  typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
  typedef logic [AXIL_DATA_W-1:0] axil_data_t;
  typedef logic [AXIL_STRB_W-1:0] axil_strb_t;
  typedef logic [AXIL_PROT_W-1:0] axil_prot_t;
  typedef logic [AXIL_RESP_W-1:0] axil_resp_t;

  // Response codes as defined by the AXI specification
  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  // AxPROT[0] marks a privileged access
  localparam int unsigned PROT_PRIV_BIT = 0;

endpackage

//--- hw/regfile_pkg.sv
/*
 * Register file geometry and contents. Base address must be aligned to 32 bytes.
 * Bytes past REG_NUM_BYTES inside the last chunk are unmapped and read as zero.
 */
package regfile_pkg;

  // Ten bytes leave the last bus-wide chunk half filled
  localparam int unsigned REG_NUM_BYTES = 10;
  localparam int unsigned NUM_CHUNKS =
      (REG_NUM_BYTES + axil_pkg::AXIL_STRB_W - 1) / axil_pkg::AXIL_STRB_W;

  // Address bits that are decoded, one more than the byte index needs
  localparam int unsigned OFFS_W = $clog2(REG_NUM_BYTES) + 1;
  // Chunk index covers the whole decoded offset so out-of-range chunks are visible
  localparam int unsigned CHUNK_IDX_W = OFFS_W - $clog2(axil_pkg::AXIL_STRB_W);

  typedef logic [CHUNK_IDX_W-1:0]     chunk_idx_t;
  typedef logic [7:0]                 reg_byte_t;
  // Byte i sits at bits [8*i +: 8]
  typedef logic [8*REG_NUM_BYTES-1:0] reg_bytes_t;
  typedef logic [REG_NUM_BYTES-1:0]   reg_mask_t;

  // Bytes 2, 3 and 8 cannot be written from the bus
  localparam reg_mask_t REG_READ_ONLY = 10'b01_0000_1100;

  // Reset values listed from byte 9 down to byte 0
  localparam reg_bytes_t REG_RST_VAL = {
    8'h9A, 8'h89, 8'h78, 8'h67, 8'h56,
    8'h45, 8'h34, 8'h23, 8'h12, 8'h01
  };

  // Unprivileged reads and writes are refused with SLVERR
  localparam bit PRIV_ONLY = 1'b1;

  // Data returned on every refused read
  localparam axil_pkg::axil_data_t ERR_RDATA = 32'hBA5E1E55;

endpackage

//--- hw/regfile_req_decode.sv
/*
 * Address and protection check for one AXI address channel.
 * Address bits above OFFS_W are ignored, so the register file aliases upward.
 */
module regfile_req_decode (
  input  axil_pkg::axil_addr_t    addr_i,
  input  axil_pkg::axil_prot_t    prot_i,
  output regfile_pkg::chunk_idx_t chunk_o,
  output logic                    allowed_o
);
  import axil_pkg::*;
  import regfile_pkg::*;

  logic [OFFS_W-1:0] offs;
  logic              in_range;
  logic              prot_ok;

  // Only the low bits of the address select a byte in this module
  assign offs = addr_i[OFFS_W-1:0];

  // Each chunk is one bus word wide
  assign chunk_o = chunk_idx_t'(offs / AXIL_STRB_W);

  // Chunks past the last mapped one answer with an error
  assign in_range = (chunk_o < NUM_CHUNKS);

  // With PRIV_ONLY set the privileged bit of AxPROT must be high
  assign prot_ok = !PRIV_ONLY || prot_i[PROT_PRIV_BIT];

  assign allowed_o = in_range && prot_ok;

endmodule

//--- hw/regfile_write_ctrl.sv
/*
 * Write acceptance for paired AW and W beats. AW and W are taken in the same cycle only.
 * b_ready_i must come from a registered source so that no loop forms through the readies.
 */
module regfile_write_ctrl (
  input  logic                    aw_valid_i,
  input  logic                    w_valid_i,
  input  axil_pkg::axil_data_t    w_data_i,
  input  axil_pkg::axil_strb_t    w_strb_i,
  input  regfile_pkg::chunk_idx_t chunk_i,
  input  logic                    allowed_i,
  input  regfile_pkg::reg_mask_t  reg_load_i,
  input  logic                    b_ready_i,
  output logic                    aw_ready_o,
  output logic                    w_ready_o,
  output logic                    b_valid_o,
  output axil_pkg::axil_resp_t    b_resp_o,
  output regfile_pkg::reg_mask_t  wr_en_o,
  output regfile_pkg::reg_bytes_t wr_data_o
);
  import axil_pkg::*;
  import regfile_pkg::*;

  reg_mask_t in_chunk;
  reg_mask_t strobed;
  reg_mask_t writable;
  logic      chunk_ro;
  logic      load_conflict;
  logic      take;

  // Map strobe lanes onto register bytes
  always_comb begin
    for (int j = 0; j < REG_NUM_BYTES; j++) begin
      // Byte j belongs to chunk j/4 and sits on lane j%4 of the bus
      in_chunk[j]          = (chunk_i == chunk_idx_t'(j / AXIL_STRB_W));
      strobed[j]           = in_chunk[j] & w_strb_i[j % AXIL_STRB_W];
      // Lane routing is fixed, so the data needs no multiplexer
      wr_data_o[8*j +: 8]  = w_data_i[8*(j % AXIL_STRB_W) +: 8];
    end
  end

  // Bytes that the bus may modify in this write
  assign writable = strobed & ~REG_READ_ONLY;

  // A chunk with no bus-writable byte at all rejects every write
  assign chunk_ro = ~(|(in_chunk & ~REG_READ_ONLY));

  // A logic load on a strobed writable byte holds the write back.
  // Refused writes never touch the store, so they do not stall
  assign load_conflict = allowed_i & (|(writable & reg_load_i));

  // Both address and data must be present and the B slot free
  assign take = aw_valid_i & w_valid_i & b_ready_i & ~load_conflict;

  assign aw_ready_o = take;
  assign w_ready_o  = take;

  // The response is pushed in the same cycle as the transfer
  assign b_valid_o = take;
  assign b_resp_o  = (allowed_i && !chunk_ro) ? RESP_OKAY : RESP_SLVERR;

  // Byte enables only fire on an accepted and allowed write
  assign wr_en_o = (take && allowed_i && !chunk_ro) ? writable : '0;

endmodule

//--- hw/regfile_byte_store.sv
/*
 * Byte registers with individual reset values. A logic load wins over a bus write.
 * Read-only bytes ignore bus writes and change only through reg_load_i.
 */
module regfile_byte_store (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  regfile_pkg::reg_mask_t  wr_en_i,
  input  regfile_pkg::reg_bytes_t wr_data_i,
  input  regfile_pkg::reg_mask_t  reg_load_i,
  input  regfile_pkg::reg_bytes_t reg_d_i,
  output regfile_pkg::reg_bytes_t reg_q_o
);
  import regfile_pkg::*;

  for (genvar j = 0; j < REG_NUM_BYTES; j++) begin : gen_byte
    reg_byte_t byte_q;
    logic      bus_wr;

    // Second guard on the read-only mask, kept local to the storage
    assign bus_wr = wr_en_i[j] & ~REG_READ_ONLY[j];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        byte_q <= REG_RST_VAL[8*j +: 8];
      end else if (reg_load_i[j]) begin
        // Logic side has priority, the write side stalls on conflicts anyway
        byte_q <= reg_d_i[8*j +: 8];
      end else if (bus_wr) begin
        byte_q <= wr_data_i[8*j +: 8];
      end
    end

    assign reg_q_o[8*j +: 8] = byte_q;
  end

endmodule

//--- hw/regfile_read_mux.sv
/*
 * Read data selection for one chunk. Purely combinational.
 * Refused reads return the fixed ERR_RDATA pattern with SLVERR.
 */
module regfile_read_mux (
  input  regfile_pkg::chunk_idx_t chunk_i,
  input  logic                    allowed_i,
  input  regfile_pkg::reg_bytes_t reg_q_i,
  output axil_pkg::axil_data_t    r_data_o,
  output axil_pkg::axil_resp_t    r_resp_o
);
  import axil_pkg::*;
  import regfile_pkg::*;

  always_comb begin
    // Error pattern unless the decoder passed the request
    r_data_o = ERR_RDATA;
    r_resp_o = RESP_SLVERR;

    if (allowed_i) begin
      // Lanes without a mapped byte stay zero
      r_data_o = '0;
      r_resp_o = RESP_OKAY;
      for (int j = 0; j < REG_NUM_BYTES; j++) begin
        // Each byte drives its fixed lane when its chunk is selected
        if (chunk_i == chunk_idx_t'(j / AXIL_STRB_W)) begin
          r_data_o[8*(j % AXIL_STRB_W) +: 8] = reg_q_i[8*j +: 8];
        end
      end
    end
  end

endmodule

//--- hw/regfile_spill.sv
/*
 * Two-entry FIFO register on a valid/ready channel. All outputs come straight from flops.
 * ready_o rises one cycle after reset release.
 */
module regfile_spill #(
  parameter int unsigned WIDTH = 1
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [WIDTH-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [WIDTH-1:0] data_o
);

  // Slot a holds the oldest entry and slot b the one behind it
  logic [WIDTH-1:0] a_q;
  logic [WIDTH-1:0] b_q;
  logic             a_full_q;
  logic             b_full_q;
  logic             a_full_d;
  logic             b_full_d;
  logic             ready_q;
  logic             push;
  logic             pop;

  assign push = valid_i & ready_q;
  assign pop  = a_full_q & ready_i;

  always_comb begin
    a_full_d = a_full_q;
    b_full_d = b_full_q;
    if (pop) begin
      // The second entry moves up, or slot a refills from the input
      if (b_full_q) begin
        b_full_d = 1'b0;
      end else begin
        a_full_d = push;
      end
    end else if (push) begin
      if (a_full_q) begin
        b_full_d = 1'b1;
      end else begin
        a_full_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
      ready_q  <= 1'b0;
    end else begin
      a_full_q <= a_full_d;
      b_full_q <= b_full_d;
      // Accept while fewer than two entries will be held
      ready_q  <= ~b_full_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop && b_full_q) begin
      a_q <= b_q;
    end else if (push && (!a_full_q || pop)) begin
      a_q <= data_i;
    end
    if (push && a_full_q && !pop) begin
      b_q <= data_i;
    end
  end

  assign ready_o = ready_q;
  assign valid_o = a_full_q;
  assign data_o  = a_q;

endmodule

//--- hw/axil_regfile_top.sv
/*
 * AXI4-Lite register file with a direct logic load port. B and R are fully registered.
 * reg_load_i on a writable byte stalls any bus write that strobes that byte.
 */
module axil_regfile_top (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  // Write address and data
  input  axil_pkg::axil_addr_t    aw_addr_i,
  input  axil_pkg::axil_prot_t    aw_prot_i,
  input  logic                    aw_valid_i,
  output logic                    aw_ready_o,
  input  axil_pkg::axil_data_t    w_data_i,
  input  axil_pkg::axil_strb_t    w_strb_i,
  input  logic                    w_valid_i,
  output logic                    w_ready_o,
  output axil_pkg::axil_resp_t    b_resp_o,
  output logic                    b_valid_o,
  input  logic                    b_ready_i,
  // Read address and data
  input  axil_pkg::axil_addr_t    ar_addr_i,
  input  axil_pkg::axil_prot_t    ar_prot_i,
  input  logic                    ar_valid_i,
  output logic                    ar_ready_o,
  output axil_pkg::axil_data_t    r_data_o,
  output axil_pkg::axil_resp_t    r_resp_o,
  output logic                    r_valid_o,
  input  logic                    r_ready_i,
  // Logic side
  input  regfile_pkg::reg_bytes_t reg_d_i,
  input  regfile_pkg::reg_mask_t  reg_load_i,
  output regfile_pkg::reg_bytes_t reg_q_o
);
  import axil_pkg::*;
  import regfile_pkg::*;

  chunk_idx_t aw_chunk;
  logic       aw_allowed;
  chunk_idx_t ar_chunk;
  logic       ar_allowed;
  logic       b_valid;
  logic       b_ready;
  axil_resp_t b_resp;
  reg_mask_t  wr_en;
  reg_bytes_t wr_data;
  axil_data_t r_data;
  axil_resp_t r_resp;
  // R channel packed as data over response
  logic [AXIL_DATA_W+AXIL_RESP_W-1:0] r_chan_in;
  logic [AXIL_DATA_W+AXIL_RESP_W-1:0] r_chan_out;

  regfile_req_decode u_aw_decode (
    .addr_i    (aw_addr_i),
    .prot_i    (aw_prot_i),
    .chunk_o   (aw_chunk),
    .allowed_o (aw_allowed)
  );

  regfile_req_decode u_ar_decode (
    .addr_i    (ar_addr_i),
    .prot_i    (ar_prot_i),
    .chunk_o   (ar_chunk),
    .allowed_o (ar_allowed)
  );

  regfile_write_ctrl u_write_ctrl (
    .aw_valid_i (aw_valid_i),
    .w_valid_i  (w_valid_i),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .chunk_i    (aw_chunk),
    .allowed_i  (aw_allowed),
    .reg_load_i (reg_load_i),
    .b_ready_i  (b_ready),
    .aw_ready_o (aw_ready_o),
    .w_ready_o  (w_ready_o),
    .b_valid_o  (b_valid),
    .b_resp_o   (b_resp),
    .wr_en_o    (wr_en),
    .wr_data_o  (wr_data)
  );

  regfile_byte_store u_byte_store (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .wr_en_i    (wr_en),
    .wr_data_i  (wr_data),
    .reg_load_i (reg_load_i),
    .reg_d_i    (reg_d_i),
    .reg_q_o    (reg_q_o)
  );

  regfile_read_mux u_read_mux (
    .chunk_i   (ar_chunk),
    .allowed_i (ar_allowed),
    .reg_q_i   (reg_q_o),
    .r_data_o  (r_data),
    .r_resp_o  (r_resp)
  );

  // B response slot, its ready gates write acceptance
  regfile_spill #(
    .WIDTH (AXIL_RESP_W)
  ) u_b_spill (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (b_valid),
    .ready_o  (b_ready),
    .data_i   (b_resp),
    .valid_o  (b_valid_o),
    .ready_i  (b_ready_i),
    .data_o   (b_resp_o)
  );

  // The AR handshake is the push into the R slot, data sampled in that cycle
  assign r_chan_in = {r_data, r_resp};

  regfile_spill #(
    .WIDTH (AXIL_DATA_W + AXIL_RESP_W)
  ) u_r_spill (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (ar_valid_i),
    .ready_o  (ar_ready_o),
    .data_i   (r_chan_in),
    .valid_o  (r_valid_o),
    .ready_i  (r_ready_i),
    .data_o   (r_chan_out)
  );

  assign r_data_o = r_chan_out[AXIL_RESP_W +: AXIL_DATA_W];
  assign r_resp_o = r_chan_out[AXIL_RESP_W-1:0];

endmodule

//--- verif/tb_clkgen.sv
/*
 * Free-running 10 ns clock. Reset is held low for 16 rising edges, released 1 ns after.
 */
module tb_clkgen (
  output logic clk_o,
  output logic arst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    // Release away from the edge, like all other stimulus
    #1 arst_n_o = 1'b1;
  end

endmodule

//--- verif/axil_regfile_chk.sv
/*
 * Protocol and storage rules on the register file ports, attached with bind.
 */
module axil_regfile_chk (
  input logic                    clk_i,
  input logic                    arst_n_i,
  input logic                    aw_valid_i,
  input logic                    aw_ready_o,
  input logic                    w_valid_i,
  input logic                    w_ready_o,
  input logic                    b_valid_o,
  input logic                    b_ready_i,
  input logic                    ar_valid_i,
  input logic                    ar_ready_o,
  input logic                    r_valid_o,
  input logic                    r_ready_i,
  input regfile_pkg::reg_mask_t  reg_load_i,
  input regfile_pkg::reg_bytes_t reg_q_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import regfile_pkg::*;

  // Nothing handshakes while the spill registers are held in reset
  assert property (@(posedge clk_i) !arst_n_i |->
                   !(aw_ready_o | w_ready_o | ar_ready_o | b_valid_o | r_valid_o))
    else $error("ready or valid output high during reset");

  // Every valid holds until its transfer
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   aw_valid_i && !aw_ready_o |=> aw_valid_i)
    else $error("aw_valid_i dropped before transfer");
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   w_valid_i && !w_ready_o |=> w_valid_i)
    else $error("w_valid_i dropped before transfer");
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   ar_valid_i && !ar_ready_o |=> ar_valid_i)
    else $error("ar_valid_i dropped before transfer");
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   b_valid_o && !b_ready_i |=> b_valid_o)
    else $error("b_valid_o dropped before transfer");
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   r_valid_o && !r_ready_i |=> r_valid_o)
    else $error("r_valid_o dropped before transfer");

  // Read-only bytes move only through the logic load
  for (genvar j = 0; j < REG_NUM_BYTES; j++) begin : gen_ro
    if (REG_READ_ONLY[j]) begin : gen_chk
      assert property (@(posedge clk_i) disable iff (!arst_n_i)
                       !reg_load_i[j] |=> $stable(reg_q_o[8*j +: 8]))
        else $error("read-only byte %0d changed without a load", j);
    end
  end

endmodule

//--- verif/axil_regfile_tb.sv
/*
 * Random test of the AXI4-Lite register file against a byte model. Seeded, so runs repeat.
 * Stimulus changes 1 ns after the rising edge, handshakes are sampled at the falling edge.
 */
module axil_regfile_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import axil_pkg::*;
  import regfile_pkg::*;

  // Rough cycle budget per test, from reset to back-pressure
  localparam int TEST_CYCLES = 16 + 30 + 40 * 10 + 100 + 120 + 60;
  localparam int MAX_CYCLES  = 2 * TEST_CYCLES + 200;
  // Chunk slots that the decoded offset can name
  localparam int ALL_CHUNKS  = (1 << OFFS_W) / AXIL_STRB_W;

  logic       clk;
  logic       arst_n;
  axil_addr_t aw_addr, ar_addr;
  axil_prot_t aw_prot, ar_prot;
  axil_data_t w_data, r_data;
  axil_strb_t w_strb;
  axil_resp_t b_resp, r_resp;
  logic       aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic       ar_valid, ar_ready, r_valid, r_ready;
  reg_bytes_t reg_d, reg_q, model_q;
  reg_mask_t  reg_load;
  int         errors, checks, cycles, err0, n_acc, got, k, b;
  logic       acc;
  axil_resp_t exp_resp_q[$];
  axil_data_t exp_data_q[$];

  tb_clkgen u_clkgen (.clk_o(clk), .arst_n_o(arst_n));

  axil_regfile_top axil_regfile_top_inst (
    .clk_i(clk), .arst_n_i(arst_n),
    .aw_addr_i(aw_addr), .aw_prot_i(aw_prot), .aw_valid_i(aw_valid), .aw_ready_o(aw_ready),
    .w_data_i(w_data), .w_strb_i(w_strb), .w_valid_i(w_valid), .w_ready_o(w_ready),
    .b_resp_o(b_resp), .b_valid_o(b_valid), .b_ready_i(b_ready),
    .ar_addr_i(ar_addr), .ar_prot_i(ar_prot), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready),
    .r_data_o(r_data), .r_resp_o(r_resp), .r_valid_o(r_valid), .r_ready_i(r_ready),
    .reg_d_i(reg_d), .reg_load_i(reg_load), .reg_q_o(reg_q)
  );

  task automatic check_resp(string name, axil_resp_t got_v, axil_resp_t exp_v);
    checks++;
    if (got_v !== exp_v) begin
      errors++;
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got_v, exp_v);
    end
  endtask

  task automatic check_data(string name, axil_data_t got_v, axil_data_t exp_v);
    checks++;
    if (got_v !== exp_v) begin
      errors++;
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got_v, exp_v);
    end
  endtask

  task automatic check_reg(string name, reg_bytes_t got_v, reg_bytes_t exp_v);
    checks++;
    if (got_v !== exp_v) begin
      errors++;
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got_v, exp_v);
    end
  endtask

  task automatic check_flag(string name, logic got_v, logic exp_v);
    checks++;
    if (got_v !== exp_v) begin
      errors++;
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got_v, exp_v);
    end
  endtask

  task automatic fail_plain(string what);
    errors++;
    $display("%s", what);
  endtask

  // A chunk refuses writes when none of its mapped bytes is bus-writable
  function automatic logic chunk_all_ro(int c);
    for (int l = 0; l < AXIL_STRB_W; l++) begin
      if (c * AXIL_STRB_W + l < REG_NUM_BYTES && !REG_READ_ONLY[c * AXIL_STRB_W + l]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // Strobe lanes of chunk c that land on a read-only or unmapped byte
  function automatic axil_strb_t ro_lanes(int c);
    axil_strb_t s;
    s = '0;
    for (int l = 0; l < AXIL_STRB_W; l++) begin
      if (c * AXIL_STRB_W + l >= REG_NUM_BYTES) begin
        s[l] = 1'b1;
      end else begin
        s[l] = REG_READ_ONLY[c * AXIL_STRB_W + l];
      end
    end
    return s;
  endfunction

  function automatic int chunk_of(axil_addr_t a);
    return a[OFFS_W-1:0] / AXIL_STRB_W;
  endfunction

  function automatic logic access_ok(axil_addr_t a, axil_prot_t p);
    return (chunk_of(a) < NUM_CHUNKS) && p[PROT_PRIV_BIT];
  endfunction

  function automatic axil_resp_t exp_wr_resp(axil_addr_t a, axil_prot_t p);
    return (access_ok(a, p) && !chunk_all_ro(chunk_of(a))) ? RESP_OKAY : RESP_SLVERR;
  endfunction

  // Bus word of a chunk as the model holds it, unmapped lanes zero
  function automatic axil_data_t model_word(int c);
    axil_data_t w;
    w = '0;
    for (int l = 0; l < AXIL_STRB_W; l++) begin
      if (c * AXIL_STRB_W + l < REG_NUM_BYTES) begin
        w[8*l +: 8] = model_q[8*(c * AXIL_STRB_W + l) +: 8];
      end
    end
    return w;
  endfunction

  // Random address in chunk c with random alias bits and byte offset
  function automatic axil_addr_t mk_addr(int c);
    axil_addr_t a;
    a = axil_addr_t'($urandom);
    a[OFFS_W-1:0] = OFFS_W'(c * AXIL_STRB_W + $urandom % AXIL_STRB_W);
    return a;
  endfunction

  function automatic axil_prot_t mk_prot(logic priv);
    axil_prot_t p;
    p = axil_prot_t'($urandom);
    p[PROT_PRIV_BIT] = priv;
    return p;
  endfunction

  task automatic step;
    @(posedge clk);
    #1;
  endtask

  // Applies the currently driven write to the model
  task automatic commit_write;
    int c;
    c = chunk_of(aw_addr);
    if (exp_wr_resp(aw_addr, aw_prot) == RESP_OKAY) begin
      for (int l = 0; l < AXIL_STRB_W; l++) begin
        if (c * AXIL_STRB_W + l < REG_NUM_BYTES && w_strb[l]
            && !REG_READ_ONLY[c * AXIL_STRB_W + l]) begin
          model_q[8*(c * AXIL_STRB_W + l) +: 8] = w_data[8*l +: 8];
        end
      end
    end
  endtask

  task automatic start_write(axil_addr_t a, axil_prot_t p, axil_data_t d, axil_strb_t s);
    aw_addr  = a;
    aw_prot  = p;
    w_data   = d;
    w_strb   = s;
    aw_valid = 1'b1;
    w_valid  = 1'b1;
  endtask

  task automatic finish_write;
    axil_resp_t exp_v;
    exp_v = exp_wr_resp(aw_addr, aw_prot);
    do @(negedge clk); while (!aw_ready);
    // W is taken in the same cycle as AW
    check_flag("w_ready_o", w_ready, 1'b1);
    commit_write();
    step();
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    do @(negedge clk); while (!b_valid);
    check_resp("b_resp_o", b_resp, exp_v);
    step();
  endtask

  task automatic do_write(axil_addr_t a, axil_prot_t p, axil_data_t d, axil_strb_t s);
    start_write(a, p, d, s);
    finish_write();
  endtask

  task automatic do_read(axil_addr_t a, axil_prot_t p);
    axil_data_t exp_d;
    ar_addr  = a;
    ar_prot  = p;
    ar_valid = 1'b1;
    do @(negedge clk); while (!ar_ready);
    // Data is taken from the store in the AR transfer cycle
    exp_d = access_ok(a, p) ? model_word(chunk_of(a)) : ERR_RDATA;
    step();
    ar_valid = 1'b0;
    do @(negedge clk); while (!r_valid);
    check_data("r_data_o", r_data, exp_d);
    check_resp("r_resp_o", r_resp, access_ok(a, p) ? RESP_OKAY : RESP_SLVERR);
    step();
  endtask

  task automatic report(int n, string name);
    $display("Test %0d %s: %s", n, name, (errors == err0) ? "passed" : "failed");
    err0 = errors;
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    {aw_addr, aw_prot, aw_valid, w_data, w_strb, w_valid} = '0;
    {ar_addr, ar_prot, ar_valid, reg_d, reg_load} = '0;
    b_ready = 1'b1;
    r_ready = 1'b1;
    errors = 0;
    checks = 0;
    cycles = 0;
    err0 = 0;
    model_q = REG_RST_VAL;
    void'($urandom(98822));
    wait (arst_n);
    step();

    // Reset contents
    check_reg("reg_q_o", reg_q, model_q);
    for (int c = 0; c < NUM_CHUNKS; c++) do_read(mk_addr(c), mk_prot(1'b1));
    report(1, "reset values");

    // Random strobed writes, each read back
    repeat (40) begin
      k = $urandom % NUM_CHUNKS;
      do_write(mk_addr(k), mk_prot(1'b1), $urandom, axil_strb_t'($urandom));
      do_read(mk_addr(k), mk_prot(1'b1));
      check_reg("reg_q_o", reg_q, model_q);
    end
    report(2, "random writes");

    // Out of range, unprivileged and fully read-only accesses
    repeat (6) begin
      k = NUM_CHUNKS + $urandom % (ALL_CHUNKS - NUM_CHUNKS);
      do_write(mk_addr(k), mk_prot(1'b1), $urandom, axil_strb_t'($urandom));
      do_read(mk_addr(k), mk_prot(1'b1));
      k = $urandom % NUM_CHUNKS;
      do_write(mk_addr(k), mk_prot(1'b0), $urandom, 4'hF);
      do_read(mk_addr(k), mk_prot(1'b0));
      check_reg("reg_q_o", reg_q, model_q);
    end
    // Only the read-only and unmapped lanes of each chunk are strobed here
    // A chunk with no bus-writable byte at all takes a full strobe and answers SLVERR
    for (int c = 0; c < NUM_CHUNKS; c++) begin
      do_write(mk_addr(c), mk_prot(1'b1), $urandom, chunk_all_ro(c) ? 4'hF : ro_lanes(c));
    end
    check_reg("reg_q_o", reg_q, model_q);
    report(3, "refused accesses");

    // Logic loads, then a write stalled by a load on its byte
    repeat (10) begin
      reg_d = reg_bytes_t'({$urandom, $urandom, $urandom});
      reg_load = reg_mask_t'($urandom);
      step();
      for (int j = 0; j < REG_NUM_BYTES; j++) begin
        if (reg_load[j]) model_q[8*j +: 8] = reg_d[8*j +: 8];
      end
      reg_load = '0;
      check_reg("reg_q_o", reg_q, model_q);
    end
    do b = $urandom % REG_NUM_BYTES; while (REG_READ_ONLY[b]);
    reg_d = reg_bytes_t'({$urandom, $urandom, $urandom});
    reg_load = reg_mask_t'(1) << b;
    model_q[8*b +: 8] = reg_d[8*b +: 8];
    start_write(mk_addr(b / AXIL_STRB_W), mk_prot(1'b1), $urandom,
                axil_strb_t'($urandom) | (axil_strb_t'(1) << (b % AXIL_STRB_W)));
    repeat (4) begin
      @(negedge clk);
      // Both readies stay low while the load hits a strobed byte
      check_flag("aw_ready_o", aw_ready, 1'b0);
      check_flag("w_ready_o", w_ready, 1'b0);
      step();
    end
    reg_load = '0;
    finish_write();
    check_reg("reg_q_o", reg_q, model_q);
    report(4, "logic loads");

    // B back-pressure, privileged and unprivileged writes alternate
    b_ready = 1'b0;
    n_acc = 0;
    k = 0;
    start_write(mk_addr(1), mk_prot(1'b1), $urandom, 4'hF);
    exp_resp_q.push_back(exp_wr_resp(aw_addr, aw_prot));
    repeat (8) begin
      @(negedge clk);
      acc = aw_ready;
      if (acc) begin
        commit_write();
        n_acc++;
      end
      step();
      if (acc && k < 2) begin
        k++;
        start_write(mk_addr(1), mk_prot(k % 2 == 0), $urandom, 4'hF);
        exp_resp_q.push_back(exp_wr_resp(aw_addr, aw_prot));
      end
    end
    if (n_acc != 2) fail_plain($sformatf("B stalled but %0d writes were accepted", n_acc));
    b_ready = 1'b1;
    got = 0;
    while (got < 3) begin
      @(negedge clk);
      acc = aw_valid && aw_ready;
      if (acc) commit_write();
      if (b_valid) begin
        check_resp("b_resp_o", b_resp, exp_resp_q.pop_front());
        got++;
      end
      step();
      if (acc) begin
        aw_valid = 1'b0;
        w_valid  = 1'b0;
      end
    end

    // R back-pressure, reads walk through the chunks
    r_ready = 1'b0;
    n_acc = 0;
    ar_addr = mk_addr(0);
    ar_prot = mk_prot(1'b1);
    ar_valid = 1'b1;
    repeat (8) begin
      @(negedge clk);
      acc = ar_ready;
      if (acc) begin
        exp_data_q.push_back(model_word(chunk_of(ar_addr)));
        n_acc++;
      end
      step();
      if (acc) ar_addr = mk_addr(n_acc);
    end
    if (n_acc != 2) fail_plain($sformatf("R stalled but %0d reads were accepted", n_acc));
    r_ready = 1'b1;
    got = 0;
    while (got < 3) begin
      @(negedge clk);
      acc = ar_valid && ar_ready;
      if (acc) exp_data_q.push_back(model_word(chunk_of(ar_addr)));
      if (r_valid) begin
        check_data("r_data_o", r_data, exp_data_q.pop_front());
        check_resp("r_resp_o", r_resp, RESP_OKAY);
        got++;
      end
      step();
      if (acc) ar_valid = 1'b0;
    end
    check_reg("reg_q_o", reg_q, model_q);
    report(5, "back-pressure");

    $display("Tests: 5, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

bind axil_regfile_top axil_regfile_chk axil_regfile_chk_inst (.*);

//--- axil_regfile.f
hw/axil_pkg.sv
hw/regfile_pkg.sv
hw/regfile_req_decode.sv
hw/regfile_write_ctrl.sv
hw/regfile_byte_store.sv
hw/regfile_read_mux.sv
hw/regfile_spill.sv
hw/axil_regfile_top.sv
verif/tb_clkgen.sv
verif/axil_regfile_chk.sv
verif/axil_regfile_tb.sv

//--- Bender.yml
package:
  name: axil_regfile

sources:
  - files:
      - hw/axil_pkg.sv
      - hw/regfile_pkg.sv
      - hw/regfile_req_decode.sv
      - hw/regfile_write_ctrl.sv
      - hw/regfile_byte_store.sv
      - hw/regfile_read_mux.sv
      - hw/regfile_spill.sv
      - hw/axil_regfile_top.sv
  - target: test
    files:
      - verif/tb_clkgen.sv
      - verif/axil_regfile_chk.sv
      - verif/axil_regfile_tb.sv
